// File: filelist.f
ic_pkg.sv
ic_ram_1p.sv
ic_scramble_ctrl.sv
ic_cache_ctrl.sv
ic_top.sv
tb_ic_mem.sv
tb_ic_top.sv

// File: ic_cache_ctrl.sv
//////////////////////////////////////////////////
// Instruction cache controller
// Lookup, line fill, bypass and invalidation FSM
// between the fetch stream and the instruction bus
//////////////////////////////////////////////////
module ic_cache_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  branch_i,
  input  ic_pkg::ic_addr_t      addr_i,
  input  logic                  ready_i,
  output logic                  valid_o,
  output ic_pkg::ic_word_t      rdata_o,
  output ic_pkg::ic_addr_t      addr_o,
  output logic                  err_o,
  output logic                  instr_req_o,
  input  logic                  instr_gnt_i,
  output ic_pkg::ic_addr_t      instr_addr_o,
  input  logic                  instr_rvalid_i,
  input  ic_pkg::ic_word_t      instr_rdata_i,
  input  logic                  instr_err_i,
  output logic [1:0]            tag_req_o,
  output logic                  tag_write_o,
  output ic_pkg::ic_index_t     tag_addr_o,
  output ic_pkg::ic_tag_entry_t tag_wdata_o,
  input  ic_pkg::ic_tag_entry_t tag_rdata_i [ic_pkg::IC_NUM_WAYS],
  output logic [1:0]            data_req_o,
  output logic                  data_write_o,
  output ic_pkg::ic_index_t     data_addr_o,
  output ic_pkg::ic_line_t      data_wdata_o,
  input  ic_pkg::ic_line_t      data_rdata_i [ic_pkg::IC_NUM_WAYS],
  input  logic                  key_valid_i,
  input  logic                  icache_enable_i,
  input  logic                  icache_inval_i,
  output logic                  busy_o
);
  import ic_pkg::*;

  ic_state_e state_q, state_d;
  ic_addr_t  fetch_addr_q, fetch_addr_d;
  ic_addr_t  fill_addr_q, fill_addr_d;
  ic_line_t  line_q, line_d;
  ic_index_t inval_cnt_q, inval_cnt_d;
  logic      err_q, err_d;
  logic      line_ok_q, line_ok_d;
  logic      abort_q, abort_d;
  logic      beat_q, beat_d;
  logic      bp_gnt_q, bp_gnt_d;
  logic      stream_q, stream_d;
  logic      inval_q, inval_d;
  logic      rr_q, rr_d;
  logic      way_q, way_d;

  logic [IC_NUM_WAYS-1:0] way_hit;
  ic_tag_t                lookup_tag;
  logic                   victim;
  logic                   can_start;
  logic                   start;

  assign lookup_tag = fetch_addr_q[IC_TAG_LSB +: IC_TAG_SIZE];

  always_comb begin
    for (int unsigned w = 0; w < IC_NUM_WAYS; w++) begin
      way_hit[w] = tag_rdata_i[w][IC_TAG_SIZE] &&
                   (tag_rdata_i[w][IC_TAG_SIZE-1:0] == lookup_tag);
    end
  end

  // First invalid way, else round robin
  assign victim = !tag_rdata_i[0][IC_TAG_SIZE] ? 1'b0 :
                  !tag_rdata_i[1][IC_TAG_SIZE] ? 1'b1 : rr_q;

  assign can_start = req_i && key_valid_i && !inval_q;

  always_comb begin
    state_d      = state_q;
    fetch_addr_d = fetch_addr_q;
    fill_addr_d  = fill_addr_q;
    line_d       = line_q;
    inval_cnt_d  = inval_cnt_q;
    err_d        = err_q;
    line_ok_d    = line_ok_q;
    abort_d      = abort_q;
    beat_d       = beat_q;
    bp_gnt_d     = bp_gnt_q;
    stream_d     = stream_q;
    inval_d      = inval_q | icache_inval_i;
    rr_d         = rr_q;
    way_d        = way_q;
    start        = 1'b0;

    tag_req_o    = '0;
    tag_write_o  = 1'b0;
    tag_addr_o   = fill_addr_q[IC_INDEX_LSB +: IC_INDEX_W];
    tag_wdata_o  = {1'b1, fill_addr_q[IC_TAG_LSB +: IC_TAG_SIZE]};
    data_req_o   = '0;
    data_write_o = 1'b0;
    data_addr_o  = fill_addr_q[IC_INDEX_LSB +: IC_INDEX_W];
    data_wdata_o = {instr_rdata_i, line_q[BUS_SIZE-1:0]};
    instr_req_o  = 1'b0;
    instr_addr_o = {fill_addr_q[31:3], beat_q, 2'b00};

    // A branch restarts the stream, bus transfers in flight are drained first
    if (branch_i) begin
      fetch_addr_d = {addr_i[31:2], 2'b00};
      stream_d     = 1'b1;
      if (state_q inside {FILL_REQ, FILL_WAIT, BYPASS}) begin
        abort_d = 1'b1;
      end
    end

    unique case (state_q)
      IDLE: begin
        if (inval_q && key_valid_i) begin
          state_d     = INVAL;
          inval_cnt_d = '0;
          inval_d     = icache_inval_i;
        end else if ((stream_q || branch_i) && can_start) begin
          start = 1'b1;
        end
      end
      LOOKUP: begin
        if (branch_i) begin
          state_d = IDLE;
          start   = can_start;
        end else if (|way_hit) begin
          line_d    = way_hit[1] ? data_rdata_i[1] : data_rdata_i[0];
          err_d     = 1'b0;
          line_ok_d = 1'b1;
          state_d   = OUTPUT;
        end else begin
          way_d       = victim;
          fill_addr_d = fetch_addr_q;
          beat_d      = 1'b0;
          err_d       = 1'b0;
          state_d     = FILL_REQ;
        end
      end
      FILL_REQ: begin
        instr_req_o = 1'b1;
        if (instr_gnt_i) begin
          state_d = FILL_WAIT;
        end
      end
      FILL_WAIT: begin
        if (instr_rvalid_i) begin
          if (beat_q) begin
            line_d[IC_LINE_W-1:BUS_SIZE] = instr_rdata_i;
          end else begin
            line_d[BUS_SIZE-1:0] = instr_rdata_i;
          end
          err_d = err_q | instr_err_i;
          if (beat_q) begin
            // Tag and data are written together on the last beat
            if (!err_d && key_valid_i) begin
              tag_req_o[way_q]  = 1'b1;
              data_req_o[way_q] = 1'b1;
              tag_write_o       = 1'b1;
              data_write_o      = 1'b1;
              rr_d              = ~rr_q;
            end
            line_ok_d = ~err_d;
            abort_d   = 1'b0;
            state_d   = (abort_q || branch_i) ? IDLE : OUTPUT;
          end else begin
            beat_d  = 1'b1;
            state_d = FILL_REQ;
          end
        end
      end
      BYPASS: begin
        instr_req_o  = ~bp_gnt_q;
        instr_addr_o = fill_addr_q;
        if (!bp_gnt_q && instr_gnt_i) begin
          bp_gnt_d = 1'b1;
        end
        if (bp_gnt_q && instr_rvalid_i) begin
          if (fill_addr_q[2]) begin
            line_d[IC_LINE_W-1:BUS_SIZE] = instr_rdata_i;
          end else begin
            line_d[BUS_SIZE-1:0] = instr_rdata_i;
          end
          err_d     = instr_err_i;
          line_ok_d = 1'b0;
          abort_d   = 1'b0;
          state_d   = (abort_q || branch_i) ? IDLE : OUTPUT;
        end
      end
      OUTPUT: begin
        if (branch_i) begin
          state_d = IDLE;
          start   = can_start;
        end else if (ready_i) begin
          fetch_addr_d = fetch_addr_q + 32'd4;
          // Second word of a resident line needs no RAM read
          if (fetch_addr_q[2] || !line_ok_q) begin
            state_d = IDLE;
          end
        end
      end
      INVAL: begin
        if (key_valid_i) begin
          tag_req_o   = '1;
          tag_write_o = 1'b1;
          tag_addr_o  = inval_cnt_q;
          tag_wdata_o = '0;
          inval_cnt_d = inval_cnt_q + 1'b1;
          if (inval_cnt_q == ic_index_t'(IC_NUM_LINES - 1)) begin
            state_d = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase

    if (start) begin
      if (icache_enable_i) begin
        tag_req_o   = '1;
        data_req_o  = '1;
        tag_addr_o  = fetch_addr_d[IC_INDEX_LSB +: IC_INDEX_W];
        data_addr_o = fetch_addr_d[IC_INDEX_LSB +: IC_INDEX_W];
        state_d     = LOOKUP;
      end else begin
        fill_addr_d = fetch_addr_d;
        bp_gnt_d    = 1'b0;
        state_d     = BYPASS;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      inval_cnt_q <= '0;
      err_q       <= 1'b0;
      line_ok_q   <= 1'b0;
      abort_q     <= 1'b0;
      beat_q      <= 1'b0;
      bp_gnt_q    <= 1'b0;
      stream_q    <= 1'b0;
      inval_q     <= 1'b1;
      rr_q        <= 1'b0;
    end else begin
      state_q     <= state_d;
      inval_cnt_q <= inval_cnt_d;
      err_q       <= err_d;
      line_ok_q   <= line_ok_d;
      abort_q     <= abort_d;
      beat_q      <= beat_d;
      bp_gnt_q    <= bp_gnt_d;
      stream_q    <= stream_d;
      inval_q     <= inval_d;
      rr_q        <= rr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    fetch_addr_q <= fetch_addr_d;
    fill_addr_q  <= fill_addr_d;
    line_q       <= line_d;
    way_q        <= way_d;
  end

  assign valid_o = (state_q == OUTPUT);
  assign rdata_o = fetch_addr_q[2] ? line_q[IC_LINE_W-1:BUS_SIZE] : line_q[BUS_SIZE-1:0];
  assign addr_o  = fetch_addr_q;
  assign err_o   = err_q;
  assign busy_o  = inval_q || (state_q == INVAL);

  // A line is only ever allocated into one way
  a_single_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == LOOKUP |-> $onehot0(way_hit));

  a_bus_addr_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

// File: ic_pkg.sv
//////////////////////////////////////////////////
// Instruction cache package
// Geometry, key reset values, shared vector types
// and the controller state encoding
//////////////////////////////////////////////////
package ic_pkg;

  // Cache geometry
  localparam int unsigned IC_NUM_WAYS    = 2;
  localparam int unsigned IC_NUM_LINES   = 16;
  localparam int unsigned IC_LINE_BEATS  = 2;
  localparam int unsigned BUS_SIZE       = 32;
  localparam int unsigned IC_INDEX_W     = 4;
  localparam int unsigned IC_TAG_SIZE    = 25;
  localparam int unsigned IC_TAG_ENTRY_W = IC_TAG_SIZE + 1;
  localparam int unsigned IC_LINE_W      = BUS_SIZE * IC_LINE_BEATS;

  // Address split, word offset is bit 2
  localparam int unsigned IC_INDEX_LSB = 3;
  localparam int unsigned IC_TAG_LSB   = IC_INDEX_LSB + IC_INDEX_W;

  // Scrambling
  localparam int unsigned SCRAMBLE_KEY_W   = 128;
  localparam int unsigned SCRAMBLE_NONCE_W = 64;

  localparam logic [SCRAMBLE_KEY_W-1:0] SCRAMBLE_KEY_RST =
    128'h3C5A_96E1_0F2D_7B48_C1A9_5E36_D20B_847F;
  localparam logic [SCRAMBLE_NONCE_W-1:0] SCRAMBLE_NONCE_RST = 64'h61D4_2B9F_E805_37CA;

  typedef logic [31:0]                 ic_addr_t;
  typedef logic [BUS_SIZE-1:0]         ic_word_t;
  typedef logic [IC_INDEX_W-1:0]       ic_index_t;
  typedef logic [IC_TAG_SIZE-1:0]      ic_tag_t;
  // Valid bit sits above the tag
  typedef logic [IC_TAG_ENTRY_W-1:0]   ic_tag_entry_t;
  // Beat 0 in the low half
  typedef logic [IC_LINE_W-1:0]        ic_line_t;
  typedef logic [SCRAMBLE_KEY_W-1:0]   scr_key_t;
  typedef logic [SCRAMBLE_NONCE_W-1:0] scr_nonce_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    FILL_REQ,
    FILL_WAIT,
    OUTPUT,
    BYPASS,
    INVAL
  } ic_state_e;

endpackage

// File: ic_ram_1p.sv
//////////////////////////////////////////////////
// Single-port scrambled RAM
// Words are stored XORed with a keystream built
// from key, nonce and address
//////////////////////////////////////////////////
module ic_ram_1p #(
  parameter int unsigned Width = 32
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         key_valid_i,
  input  ic_pkg::scr_key_t             key_i,
  input  ic_pkg::scr_nonce_t           nonce_i,
  input  logic                         req_i,
  input  logic                         write_i,
  input  ic_pkg::ic_index_t            addr_i,
  input  logic [Width-1:0]             wdata_i,
  output logic [Width-1:0]             rdata_o
);
  import ic_pkg::*;

  logic [Width-1:0] mem_q [IC_NUM_LINES];
  logic [Width-1:0] rdata_q;
  logic [Width-1:0] ks;
  scr_nonce_t       seed;
  scr_nonce_t       mix;

  // Keystream for the addressed entry
  always_comb begin
    seed = key_i[127:64] ^ key_i[63:0] ^ nonce_i ^
           (scr_nonce_t'(addr_i) * 64'h9E37_79B9_7F4A_7C15);
    mix  = seed ^ {seed[40:0], seed[63:41]} ^ {seed[12:0], seed[63:13]};
    for (int unsigned i = 0; i < Width; i++) begin
      ks[i] = mix[i % SCRAMBLE_NONCE_W];
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && key_valid_i) begin
      if (write_i) begin
        mem_q[addr_i] <= wdata_i ^ ks;
      end else begin
        rdata_q <= mem_q[addr_i] ^ ks;
      end
    end
  end

  assign rdata_o = rdata_q;

  // Controller must hold off while the key manager is rekeying
  a_req_with_key : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> key_valid_i);

endmodule

// File: ic_scramble_ctrl.sv
//////////////////////////////////////////////////
// Scramble key manager
// Holds key and nonce, requests a new key after
// every cache invalidation
//////////////////////////////////////////////////
module ic_scramble_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               icache_inval_i,
  input  logic               scramble_key_valid_i,
  input  ic_pkg::scr_key_t   scramble_key_i,
  input  ic_pkg::scr_nonce_t scramble_nonce_i,
  output logic               scramble_req_o,
  output logic               key_valid_o,
  output ic_pkg::scr_key_t   key_o,
  output ic_pkg::scr_nonce_t nonce_o
);
  import ic_pkg::*;

  logic       req_q;
  logic       key_valid_q;
  scr_key_t   key_q;
  scr_nonce_t nonce_q;

  // Request stays up until the key source answers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else if (req_q) begin
      if (scramble_key_valid_i) begin
        req_q       <= 1'b0;
        key_valid_q <= 1'b1;
      end
    end else if (icache_inval_i) begin
      req_q       <= 1'b1;
      key_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= SCRAMBLE_KEY_RST;
      nonce_q <= SCRAMBLE_NONCE_RST;
    end else if (req_q && scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = key_valid_q;
  assign key_o          = key_q;
  assign nonce_o        = nonce_q;

  // Key source only answers a pending request
  a_key_with_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    scramble_key_valid_i |-> scramble_req_o);

endmodule

// File: ic_top.sv
//////////////////////////////////////////////////
// Instruction cache top level
// Controller, key manager and per-way tag and
// data RAMs
//////////////////////////////////////////////////
module ic_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               branch_i,
  input  ic_pkg::ic_addr_t   addr_i,
  input  logic               ready_i,
  output logic               valid_o,
  output ic_pkg::ic_word_t   rdata_o,
  output ic_pkg::ic_addr_t   addr_o,
  output logic               err_o,
  output logic               instr_req_o,
  input  logic               instr_gnt_i,
  output ic_pkg::ic_addr_t   instr_addr_o,
  input  ic_pkg::ic_word_t   instr_rdata_i,
  input  logic               instr_err_i,
  input  logic               instr_rvalid_i,
  input  logic               scramble_key_valid_i,
  input  ic_pkg::scr_key_t   scramble_key_i,
  input  ic_pkg::scr_nonce_t scramble_nonce_i,
  output logic               scramble_req_o,
  input  logic               icache_enable_i,
  input  logic               icache_inval_i,
  output logic               busy_o
);
  import ic_pkg::*;

  logic [IC_NUM_WAYS-1:0] tag_req;
  logic                   tag_write;
  ic_index_t              tag_addr;
  ic_tag_entry_t          tag_wdata;
  ic_tag_entry_t          tag_rdata [IC_NUM_WAYS];
  logic [IC_NUM_WAYS-1:0] data_req;
  logic                   data_write;
  ic_index_t              data_addr;
  ic_line_t               data_wdata;
  ic_line_t               data_rdata [IC_NUM_WAYS];

  logic       key_valid;
  scr_key_t   key;
  scr_nonce_t nonce;

  ic_cache_ctrl i_ic_cache_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (branch_i),
    .addr_i          (addr_i),
    .ready_i         (ready_i),
    .valid_o         (valid_o),
    .rdata_o         (rdata_o),
    .addr_o          (addr_o),
    .err_o           (err_o),
    .instr_req_o     (instr_req_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_addr_o    (instr_addr_o),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_err_i     (instr_err_i),
    .tag_req_o       (tag_req),
    .tag_write_o     (tag_write),
    .tag_addr_o      (tag_addr),
    .tag_wdata_o     (tag_wdata),
    .tag_rdata_i     (tag_rdata),
    .data_req_o      (data_req),
    .data_write_o    (data_write),
    .data_addr_o     (data_addr),
    .data_wdata_o    (data_wdata),
    .data_rdata_i    (data_rdata),
    .key_valid_i     (key_valid),
    .icache_enable_i (icache_enable_i),
    .icache_inval_i  (icache_inval_i),
    .busy_o          (busy_o)
  );

  ic_scramble_ctrl i_ic_scramble_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .icache_inval_i       (icache_inval_i),
    .scramble_key_valid_i (scramble_key_valid_i),
    .scramble_key_i       (scramble_key_i),
    .scramble_nonce_i     (scramble_nonce_i),
    .scramble_req_o       (scramble_req_o),
    .key_valid_o          (key_valid),
    .key_o                (key),
    .nonce_o              (nonce)
  );

  //////////////////////////////////////////////////
  // Tag and data RAMs per way
  //////////////////////////////////////////////////
  for (genvar w = 0; w < IC_NUM_WAYS; w++) begin : gen_ways
    ic_ram_1p #(
      .Width (IC_TAG_ENTRY_W)
    ) i_tag_ram (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .key_valid_i (key_valid),
      .key_i       (key),
      .nonce_i     (nonce),
      .req_i       (tag_req[w]),
      .write_i     (tag_write),
      .addr_i      (tag_addr),
      .wdata_i     (tag_wdata),
      .rdata_o     (tag_rdata[w])
    );

    ic_ram_1p #(
      .Width (IC_LINE_W)
    ) i_data_ram (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .key_valid_i (key_valid),
      .key_i       (key),
      .nonce_i     (nonce),
      .req_i       (data_req[w]),
      .write_i     (data_write),
      .addr_i      (data_addr),
      .wdata_i     (data_wdata),
      .rdata_o     (data_rdata[w])
    );
  end

endmodule

// File: tb_ic_mem.sv
//////////////////////////////////////////////////
// Instruction bus memory model
// Random grant delay, address based data, one
// error window and a count of returned beats
//////////////////////////////////////////////////
module tb_ic_mem #(
  parameter logic [31:0] ErrBase = 32'h0000_3040
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  ic_pkg::ic_addr_t addr_i,
  output logic             gnt_o,
  output logic             rvalid_o,
  output ic_pkg::ic_word_t rdata_o,
  output logic             err_o,
  output int unsigned      beats_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned delay_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      beats_o  <= 0;
      delay_q  <= 0;
    end else begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      if (gnt_o && req_i) begin
        // One response per grant, in the following cycle
        rvalid_o <= 1'b1;
        rdata_o  <= {addr_i[24:0], addr_i[31:25]} ^ 32'hA5C3_0F1E;
        err_o    <= (addr_i >= ErrBase) && (addr_i < ErrBase + 32'd8);
        beats_o  <= beats_o + 1;
        delay_q  <= $urandom_range(3, 0);
      end else if (req_i && !gnt_o) begin
        if (delay_q == 0) begin
          gnt_o <= 1'b1;
        end else begin
          delay_q <= delay_q - 1;
        end
      end
    end
  end

endmodule

// File: tb_ic_top.sv
//////////////////////////////////////////////////
// Instruction cache testbench
// Table driven fetch streams against a bus memory
// model, with a responder for rekey requests
//////////////////////////////////////////////////
module tb_ic_top;
  timeunit 1ns;
  timeprecision 100ps;
  import ic_pkg::*;

  localparam int unsigned Timeout = 500;
  localparam int unsigned NumRows = 15;
  localparam ic_addr_t    ErrBase = 32'h0000_3040;

  typedef struct {
    ic_addr_t    addr;
    int unsigned words;
    bit          enable;
    bit          inval;
    int unsigned beats;
  } row_t;

  // Beats follow the victim rule, round robin pointer starts at way 0
  row_t rows [NumRows] = '{
    '{32'h0000_1000, 8, 1'b1, 1'b0, 8},  // cold misses on indices 0 to 3
    '{32'h0000_1004, 3, 1'b1, 1'b0, 0},
    '{32'h0000_1080, 4, 1'b1, 1'b0, 4},  // fills way 1 of indices 0 and 1
    '{32'h0000_1100, 2, 1'b1, 1'b0, 2},  // evicts 1000 from way 0
    '{32'h0000_1000, 4, 1'b1, 1'b0, 2},  // evicts 1080 from way 1
    '{32'h0000_1100, 2, 1'b1, 1'b0, 0},
    '{32'h0000_1080, 2, 1'b1, 1'b0, 2},  // evicts 1100 from way 0
    '{32'h0000_3038, 4, 1'b1, 1'b0, 6},  // error line refetched per word
    '{32'h0000_3040, 1, 1'b1, 1'b0, 2},
    '{32'h0000_2000, 3, 1'b0, 1'b0, 3},  // bypass, one beat per word
    '{32'h0000_1000, 2, 1'b0, 1'b0, 2},
    '{32'h0000_1000, 4, 1'b1, 1'b0, 0},  // still resident after bypass
    '{32'h0000_1000, 4, 1'b1, 1'b1, 4},
    '{32'h0000_1100, 2, 1'b1, 1'b0, 2},
    '{32'h0000_1000, 2, 1'b1, 1'b0, 0}
  };

  logic        clk_i;
  logic        rst_ni;
  logic        req_i;
  logic        branch_i;
  ic_addr_t    addr_i;
  logic        ready_i;
  logic        valid_o;
  ic_word_t    rdata_o;
  ic_addr_t    addr_o;
  logic        err_o;
  logic        instr_req_o;
  logic        instr_gnt_i;
  ic_addr_t    instr_addr_o;
  ic_word_t    instr_rdata_i;
  logic        instr_err_i;
  logic        instr_rvalid_i;
  logic        scramble_key_valid_i;
  scr_key_t    scramble_key_i;
  scr_nonce_t  scramble_nonce_i;
  logic        scramble_req_o;
  logic        icache_enable_i;
  logic        icache_inval_i;
  logic        busy_o;
  int unsigned mem_beats;
  int unsigned key_delay;
  int unsigned beats_before;

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  ic_top i_ic_top (.*);

  tb_ic_mem #(
    .ErrBase (ErrBase)
  ) i_mem (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i),
    .err_o    (instr_err_i),
    .beats_o  (mem_beats)
  );

  // New random key some cycles after each request
  always begin
    @(negedge clk_i);
    if (scramble_req_o === 1'b1 && !scramble_key_valid_i) begin
      key_delay = $urandom_range(5, 0);
      repeat (key_delay) @(posedge clk_i);
      @(posedge clk_i);
      scramble_key_valid_i <= 1'b1;
      scramble_key_i       <= {$urandom(), $urandom(), $urandom(), $urandom()};
      scramble_nonce_i     <= {$urandom(), $urandom()};
      @(posedge clk_i);
      scramble_key_valid_i <= 1'b0;
    end
  end

  function automatic ic_word_t mem_word(input ic_addr_t a);
    return {a[24:0], a[31:25]} ^ 32'hA5C3_0F1E;
  endfunction

  function automatic bit in_err_window(input ic_addr_t a);
    return (a >= ErrBase) && (a < ErrBase + 32'd8);
  endfunction

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  task automatic stop_on_error();
    $display("Errors found");
    $fatal(1, "Stopped at first mismatch");
  endtask

  task automatic check_word(input ic_word_t got, input ic_word_t exp, input string name);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_addr(input ic_addr_t got, input ic_addr_t exp, input string name);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input bit got, input bit exp, input string name);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string name);
    if (got != exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  task automatic wait_level(input bit scr, input logic level, input string what);
    int unsigned n;
    logic        v;
    n = 0;
    v = ~level;
    while (v !== level) begin
      @(negedge clk_i);
      v = scr ? scramble_req_o : busy_o;
      n++;
      if (n > Timeout) begin
        $display("Timeout waiting for %s", what);
        stop_on_error();
      end
    end
  endtask

  task automatic start_stream(input ic_addr_t start, input bit enable);
    @(posedge clk_i);
    icache_enable_i <= enable;
    req_i           <= 1'b1;
    branch_i        <= 1'b1;
    addr_i          <= start;
    ready_i         <= 1'b0;
    @(posedge clk_i);
    branch_i <= 1'b0;
  endtask

  // Takes words under random ready, the last one drops the request if stop is set
  task automatic consume_words(input ic_addr_t start, input int unsigned words,
                               input bit stop);
    ic_addr_t    exp_addr;
    int unsigned done;
    int unsigned idle;
    exp_addr = start;
    done     = 0;
    idle     = 0;
    while (done < words) begin
      ready_i <= ($urandom_range(3, 0) != 0);
      @(negedge clk_i);
      if (valid_o && ready_i) begin
        check_addr(addr_o, exp_addr, "addr_o");
        check_word(rdata_o, mem_word(exp_addr), "rdata_o");
        check_flag(err_o, in_err_window(exp_addr), "err_o");
        exp_addr = exp_addr + 32'd4;
        done++;
        idle = 0;
      end else begin
        idle++;
        if (idle > Timeout) begin
          $display("Timeout waiting for a word at %h", exp_addr);
          stop_on_error();
        end
      end
      @(posedge clk_i);
    end
    ready_i <= 1'b0;
    if (stop) begin
      req_i <= 1'b0;
    end
  endtask

  // Branch with no request leaves the controller idle
  task automatic park_stream();
    @(posedge clk_i);
    branch_i <= 1'b1;
    addr_i   <= '0;
    @(posedge clk_i);
    branch_i <= 1'b0;
  endtask

  task automatic invalidate_cache();
    @(posedge clk_i);
    icache_inval_i <= 1'b1;
    @(posedge clk_i);
    icache_inval_i <= 1'b0;
    wait_level(1'b1, 1'b1, "scramble_req_o to rise");
    check_flag(busy_o, 1'b1, "busy_o");
    wait_level(1'b1, 1'b0, "scramble_req_o to fall");
    wait_level(1'b0, 1'b0, "busy_o to fall after rekey");
  endtask

  initial begin
    void'($urandom(32'h727b));
    rst_ni               = 1'b0;
    req_i                = 1'b0;
    branch_i             = 1'b0;
    addr_i               = '0;
    ready_i              = 1'b0;
    scramble_key_valid_i = 1'b0;
    scramble_key_i       = '0;
    scramble_nonce_i     = '0;
    icache_enable_i      = 1'b1;
    icache_inval_i       = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    @(negedge clk_i);
    check_flag(valid_o, 1'b0, "valid_o");
    check_flag(instr_req_o, 1'b0, "instr_req_o");
    check_flag(scramble_req_o, 1'b0, "scramble_req_o");
    check_flag(busy_o, 1'b1, "busy_o");
    wait_level(1'b0, 1'b0, "busy_o to fall after reset");

    for (int i = 0; i < NumRows; i++) begin
      if (rows[i].inval) begin
        invalidate_cache();
      end
      beats_before = mem_beats;
      start_stream(rows[i].addr, rows[i].enable);
      consume_words(rows[i].addr, rows[i].words, 1'b1);
      park_stream();
      check_count(int'(mem_beats - beats_before), int'(rows[i].beats), "beats");
    end

    // Branch while the next line is still being filled
    start_stream(32'h0000_5000, 1'b1);
    consume_words(32'h0000_5000, 2, 1'b0);
    repeat (3) @(posedge clk_i);
    start_stream(32'h0000_5800, 1'b1);
    consume_words(32'h0000_5800, 4, 1'b1);

    $display("No errors");
    $finish;
  end

endmodule
